// File: flist.f
+incdir+src
src/core_pkg.sv
src/isa_decoder.sv
src/register_file.sv
src/de_pipeline_register.sv
src/alu_unit.sv
src/address_unit.sv
src/result_merge.sv
src/exec_core_top.sv
test/exec_core_tb.sv

// File: src/address_unit.sv
`timescale 1ns/1ps
`default_nettype none

module address_unit
(
    input  wire core_pkg::decoded_t decoded,
    output core_pkg::word_t         addr_value
);

    import core_pkg::*;

    word_t base;
    word_t offset;

    assign base = decoded.src1_value;

    always_comb
    begin
        case (decoded.ctrl.alu_op)
            // Index is scaled to 2-byte words.
            OP_LEA:  offset = decoded.src2_value << 1;
            OP_ST:   offset = decoded.imm;
            default: offset = '0;
        endcase
    end

    // Sum wraps at the word width.
    assign addr_value = decoded.ctrl.is_addr ? word_t'(base + offset) : '0;

endmodule

`default_nettype wire

// File: src/alu_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_defs.svh"

module alu_unit
(
    input  wire core_pkg::decoded_t decoded,
    output core_pkg::word_t         alu_value
);

    import core_pkg::*;

    localparam int SHAMT_W = $clog2(`DATA_W);

    word_t              operand_a;
    word_t              operand_b;
    logic [SHAMT_W-1:0] shamt;

    assign operand_a = decoded.src1_value;
    // ADDI takes the immediate in place of src2.
    assign operand_b = decoded.ctrl.use_imm ? decoded.imm : decoded.src2_value;
    assign shamt     = decoded.src2_value[SHAMT_W-1:0];

    always_comb
    begin
        case (decoded.ctrl.alu_op)
            OP_ADD:  alu_value = operand_a + operand_b;
            OP_SUB:  alu_value = operand_a - operand_b;
            OP_AND:  alu_value = operand_a & operand_b;
            OP_OR:   alu_value = operand_a | operand_b;
            OP_XOR:  alu_value = operand_a ^ operand_b;
            OP_SHL:  alu_value = operand_a << shamt;
            OP_SHR:  alu_value = operand_a >> shamt;
            OP_LDI:  alu_value = decoded.imm;
            OP_ADDI: alu_value = operand_a + operand_b;
            default: alu_value = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: src/core_defs.svh
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// Width of one data word.
`define DATA_W 16

// Registers in the register file.
`define REG_COUNT 16

// Bits needed to name one register.
`define REG_NUM_W 4

`endif

// File: src/core_pkg.sv
`default_nettype none

`include "core_defs.svh"

package core_pkg;

    typedef logic [`DATA_W-1:0]    word_t;
    typedef logic [`REG_NUM_W-1:0] reg_num_t;
    typedef logic [3:0]            opcode_t;

    // Codes 12 to 15 are unused and behave as NOP.
    localparam opcode_t OP_NOP  = 4'd0;
    localparam opcode_t OP_ADD  = 4'd1;
    localparam opcode_t OP_SUB  = 4'd2;
    localparam opcode_t OP_AND  = 4'd3;
    localparam opcode_t OP_OR   = 4'd4;
    localparam opcode_t OP_XOR  = 4'd5;
    localparam opcode_t OP_SHL  = 4'd6;
    localparam opcode_t OP_SHR  = 4'd7;
    localparam opcode_t OP_LDI  = 4'd8;
    localparam opcode_t OP_ADDI = 4'd9;
    localparam opcode_t OP_LEA  = 4'd10;
    localparam opcode_t OP_ST   = 4'd11;

    typedef struct packed {
        opcode_t  opcode;
        reg_num_t dst;
        reg_num_t src1;
        reg_num_t src2;
    } instr_t;

    typedef struct packed {
        logic    valid;
        opcode_t alu_op;
        logic    use_imm;
        logic    reg_write;
        logic    is_addr;   // Result taken from the address unit.
        logic    is_store;
    } ctrl_t;

    typedef struct packed {
        ctrl_t    ctrl;
        reg_num_t dst_num;
        word_t    dst_value;
        reg_num_t src1_num;
        word_t    src1_value;
        reg_num_t src2_num;
        word_t    src2_value;
        word_t    imm;
    } decoded_t;

    typedef struct packed {
        logic     valid;
        logic     reg_write;
        reg_num_t dst_num;
        word_t    value;
        logic     store_en;
        word_t    address;
        word_t    store_data;
    } result_t;

endpackage

`default_nettype wire

// File: src/de_pipeline_register.sv
`timescale 1ns/1ps
`default_nettype none

module de_pipeline_register
(
    input  wire logic               clk,
    input  wire logic               reset,
    input  wire core_pkg::decoded_t decoded_in,
    output core_pkg::decoded_t      decoded_out
);

    // Decode/execute boundary.
    // The whole bundle moves every cycle since the pipeline never stalls.
    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            // Zero bundle is a bubble.
            decoded_out <= '0;
        end
        else
        begin
            decoded_out <= decoded_in;
        end
    end

endmodule

`default_nettype wire

// File: src/exec_core_top.sv
`timescale 1ns/1ps
`default_nettype none

module exec_core_top
(
    input  wire logic             clk,
    input  wire logic             reset,
    input  wire logic             instr_valid,
    input  wire core_pkg::instr_t instr,
    output core_pkg::result_t     result
);

    import core_pkg::*;

    reg_num_t rd_num_a;
    reg_num_t rd_num_b;
    reg_num_t rd_num_c;
    word_t    rd_value_a;
    word_t    rd_value_b;
    word_t    rd_value_c;

    logic     wr_en;
    reg_num_t wr_num;
    word_t    wr_value;

    decoded_t decoded_d;
    decoded_t decoded_e;
    word_t    alu_value;
    word_t    addr_value;

    // Decode stage.
    isa_decoder isa_decoder_inst
    (
        .instr_valid (instr_valid),
        .instr       (instr),
        .rd_num_a    (rd_num_a),
        .rd_num_b    (rd_num_b),
        .rd_num_c    (rd_num_c),
        .rd_value_a  (rd_value_a),
        .rd_value_b  (rd_value_b),
        .rd_value_c  (rd_value_c),
        .decoded     (decoded_d)
    );

    register_file register_file_inst
    (
        .clk        (clk),
        .reset      (reset),
        .rd_num_a   (rd_num_a),
        .rd_num_b   (rd_num_b),
        .rd_num_c   (rd_num_c),
        .rd_value_a (rd_value_a),
        .rd_value_b (rd_value_b),
        .rd_value_c (rd_value_c),
        .wr_en      (wr_en),
        .wr_num     (wr_num),
        .wr_value   (wr_value)
    );

    de_pipeline_register de_pipeline_register_inst
    (
        .clk         (clk),
        .reset       (reset),
        .decoded_in  (decoded_d),
        .decoded_out (decoded_e)
    );

    // Execute stage.
    alu_unit alu_unit_inst
    (
        .decoded   (decoded_e),
        .alu_value (alu_value)
    );

    address_unit address_unit_inst
    (
        .decoded    (decoded_e),
        .addr_value (addr_value)
    );

    result_merge result_merge_inst
    (
        .clk        (clk),
        .reset      (reset),
        .decoded    (decoded_e),
        .alu_value  (alu_value),
        .addr_value (addr_value),
        .wr_en      (wr_en),
        .wr_num     (wr_num),
        .wr_value   (wr_value),
        .result     (result)
    );

endmodule

`default_nettype wire

// File: src/isa_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module isa_decoder
(
    input  wire logic               instr_valid,
    input  wire core_pkg::instr_t   instr,
    output core_pkg::reg_num_t      rd_num_a,
    output core_pkg::reg_num_t      rd_num_b,
    output core_pkg::reg_num_t      rd_num_c,
    input  wire core_pkg::word_t    rd_value_a,
    input  wire core_pkg::word_t    rd_value_b,
    input  wire core_pkg::word_t    rd_value_c,
    output core_pkg::decoded_t      decoded
);

    import core_pkg::*;

    ctrl_t ctrl;
    word_t imm;

    // Ports a, b and c read src1, src2 and dst.
    assign rd_num_a = instr.src1;
    assign rd_num_b = instr.src2;
    assign rd_num_c = instr.dst;

    always_comb
    begin
        ctrl        = '0;
        ctrl.valid  = instr_valid;
        ctrl.alu_op = instr.opcode;
        imm         = '0;
        case (instr.opcode)
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SHL, OP_SHR:
            begin
                ctrl.reg_write = 1'b1;
            end
            OP_LDI:
            begin
                ctrl.use_imm   = 1'b1;
                ctrl.reg_write = 1'b1;
                imm            = word_t'({instr.src1, instr.src2});
            end
            OP_ADDI:
            begin
                ctrl.use_imm   = 1'b1;
                ctrl.reg_write = 1'b1;
                imm            = word_t'(signed'(instr.src2));
            end
            OP_LEA:
            begin
                ctrl.reg_write = 1'b1;
                ctrl.is_addr   = 1'b1;
            end
            OP_ST:
            begin
                ctrl.use_imm  = 1'b1;
                ctrl.is_addr  = 1'b1;
                ctrl.is_store = 1'b1;
                imm           = word_t'(signed'(instr.src2));
            end
            default:
            begin
                ctrl.alu_op = OP_NOP;
            end
        endcase
        // A bubble must not write or store.
        if (!instr_valid)
        begin
            ctrl.reg_write = 1'b0;
            ctrl.is_store  = 1'b0;
        end
    end

    always_comb
    begin
        decoded            = '0;
        decoded.ctrl       = ctrl;
        decoded.dst_num    = instr.dst;
        decoded.dst_value  = rd_value_c;
        decoded.src1_num   = instr.src1;
        decoded.src1_value = rd_value_a;
        decoded.src2_num   = instr.src2;
        decoded.src2_value = rd_value_b;
        decoded.imm        = imm;
    end

endmodule

`default_nettype wire

// File: src/register_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_defs.svh"

module register_file
(
    input  wire logic               clk,
    input  wire logic               reset,
    input  wire core_pkg::reg_num_t rd_num_a,
    input  wire core_pkg::reg_num_t rd_num_b,
    input  wire core_pkg::reg_num_t rd_num_c,
    output core_pkg::word_t         rd_value_a,
    output core_pkg::word_t         rd_value_b,
    output core_pkg::word_t         rd_value_c,
    input  wire logic               wr_en,
    input  wire core_pkg::reg_num_t wr_num,
    input  wire core_pkg::word_t    wr_value
);

    import core_pkg::*;

    word_t regs [`REG_COUNT];

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            for (int i = 0; i < `REG_COUNT; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (wr_en)
        begin
            regs[wr_num] <= wr_value;
        end
    end

    // A read of the register being written sees the new value.
    assign rd_value_a = (wr_en && (wr_num == rd_num_a)) ? wr_value : regs[rd_num_a];
    assign rd_value_b = (wr_en && (wr_num == rd_num_b)) ? wr_value : regs[rd_num_b];
    assign rd_value_c = (wr_en && (wr_num == rd_num_c)) ? wr_value : regs[rd_num_c];

endmodule

`default_nettype wire

// File: src/result_merge.sv
`timescale 1ns/1ps
`default_nettype none

module result_merge
(
    input  wire logic               clk,
    input  wire logic               reset,
    input  wire core_pkg::decoded_t decoded,
    input  wire core_pkg::word_t    alu_value,
    input  wire core_pkg::word_t    addr_value,
    output logic                    wr_en,
    output core_pkg::reg_num_t      wr_num,
    output core_pkg::word_t         wr_value,
    output core_pkg::result_t       result
);

    import core_pkg::*;

    word_t   merged_value;
    logic    store_req;
    result_t result_next;

    assign merged_value = decoded.ctrl.is_addr ? addr_value : alu_value;
    assign store_req    = decoded.ctrl.valid && decoded.ctrl.is_store;

    // Write-back goes straight to the register file in the execute cycle.
    assign wr_en    = decoded.ctrl.valid && decoded.ctrl.reg_write;
    assign wr_num   = decoded.dst_num;
    assign wr_value = merged_value;

    always_comb
    begin
        result_next            = '0;
        result_next.valid      = decoded.ctrl.valid;
        result_next.reg_write  = wr_en;
        result_next.dst_num    = decoded.dst_num;
        result_next.value      = merged_value;
        result_next.store_en   = store_req;
        // Store data comes from the register named in dst.
        result_next.address    = store_req ? addr_value : '0;
        result_next.store_data = store_req ? decoded.dst_value : '0;
    end

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            result <= '0;
        end
        else
        begin
            result <= result_next;
        end
    end

endmodule

`default_nettype wire

// File: test/exec_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module exec_core_tb;

    import core_pkg::*;

    localparam int RANDOM_COUNT = 64;
    localparam int DRAIN_LIMIT  = 20;

    typedef struct packed {
        logic   valid;
        instr_t instr;
        word_t  value;
    } stim_t;

    logic    clk = 1'b0;
    logic    reset;
    logic    instr_valid;
    instr_t  instr;
    result_t result;

    word_t       model_regs [16];
    result_t     exp_q [$];
    stim_t       stim_table [$];
    logic [31:0] lfsr_state = 32'h011e_15d7;

    exec_core_top exec_core_top_inst
    (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr       (instr),
        .result      (result)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        // Taps 32, 22, 2, 1.
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic lfsr_take(input int n, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_state = lfsr_step(lfsr_state);
            bits = {bits[30:0], lfsr_state[0]};
        end
    endtask

    task automatic add_row(input logic v, input opcode_t op, input reg_num_t d,
                           input reg_num_t a, input reg_num_t b, input word_t value);
        stim_t s;
        s.valid = v;
        s.instr = {op, d, a, b};
        s.value = value;
        stim_table.push_back(s);
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected)
        begin
            $display("** Error: %s is 0x%h, expected 0x%h", name, actual, expected);
            $display("test failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // In-order ISA model where every instruction sees all earlier writes.
    task automatic model_apply(input instr_t ins, output result_t r);
        word_t a;
        word_t b;
        word_t d;
        word_t simm;
        a    = model_regs[ins.src1];
        b    = model_regs[ins.src2];
        d    = model_regs[ins.dst];
        simm = {{12{ins.src2[3]}}, ins.src2};
        r           = '0;
        r.valid     = 1'b1;
        r.dst_num   = ins.dst;
        r.reg_write = 1'b1;
        case (ins.opcode)
            OP_ADD:  r.value = a + b;
            OP_SUB:  r.value = a - b;
            OP_AND:  r.value = a & b;
            OP_OR:   r.value = a | b;
            OP_XOR:  r.value = a ^ b;
            OP_SHL:  r.value = a << b[3:0];
            OP_SHR:  r.value = a >> b[3:0];
            OP_LDI:  r.value = {8'h00, ins.src1, ins.src2};
            OP_ADDI: r.value = a + simm;
            OP_LEA:  r.value = a + (b << 1);
            OP_ST:
            begin
                r.reg_write  = 1'b0;
                r.store_en   = 1'b1;
                r.address    = a + simm;
                r.value      = a + simm;
                r.store_data = d;
            end
            // NOP and codes 12 to 15.
            default: r.reg_write = 1'b0;
        endcase
        if (r.reg_write)
        begin
            model_regs[ins.dst] = r.value;
        end
    endtask

    task automatic check_output();
        result_t exp;
        if (result.valid)
        begin
            if (exp_q.size() == 0)
            begin
                $display("Result for register %0d appeared with no instruction outstanding",
                         result.dst_num);
                $display("test failed");
                $fatal(1, "unexpected result");
            end
            else
            begin
                exp = exp_q.pop_front();
                check_value("result.reg_write", result.reg_write, exp.reg_write);
                check_value("result.dst_num", result.dst_num, exp.dst_num);
                check_value("result.value", result.value, exp.value);
                check_value("result.store_en", result.store_en, exp.store_en);
                check_value("result.address", result.address, exp.address);
                check_value("result.store_data", result.store_data, exp.store_data);
            end
        end
        else
        begin
            check_value("result.reg_write", result.reg_write, 1'b0);
            check_value("result.store_en", result.store_en, 1'b0);
        end
    endtask

    // Each cycle samples the output and then drives the next instruction.
    task automatic issue_cycle(input logic v, input instr_t ins, input logic fixed,
                               input word_t fixed_value);
        result_t exp;
        @(negedge clk);
        check_output();
        instr_valid = v;
        instr       = ins;
        if (v)
        begin
            model_apply(ins, exp);
            if (fixed)
            begin
                exp.value = fixed_value;
            end
            exp_q.push_back(exp);
        end
    endtask

    task automatic build_table();
        // Idle cycles after reset and an ADD of zeroed registers.
        add_row(1'b0, OP_NOP,  4'd0,  4'd0,  4'd0,  16'h0000);
        add_row(1'b0, OP_NOP,  4'd0,  4'd0,  4'd0,  16'h0000);
        add_row(1'b1, OP_ADD,  4'd1,  4'd2,  4'd3,  16'h0000);
        // Constants and register-register ops.
        add_row(1'b1, OP_LDI,  4'd1,  4'h5,  4'hA,  16'h005A);
        add_row(1'b1, OP_LDI,  4'd2,  4'hC,  4'h3,  16'h00C3);
        add_row(1'b1, OP_LDI,  4'd3,  4'h0,  4'hF,  16'h000F);
        add_row(1'b1, OP_ADD,  4'd4,  4'd1,  4'd2,  16'h011D);
        add_row(1'b1, OP_SUB,  4'd5,  4'd1,  4'd2,  16'hFF97);
        add_row(1'b1, OP_AND,  4'd6,  4'd2,  4'd3,  16'h0003);
        add_row(1'b1, OP_OR,   4'd7,  4'd1,  4'd3,  16'h005F);
        add_row(1'b1, OP_XOR,  4'd8,  4'd1,  4'd2,  16'h0099);
        add_row(1'b1, OP_LDI,  4'd9,  4'h0,  4'h0,  16'h0000);
        add_row(1'b1, OP_SHL,  4'd10, 4'd2,  4'd9,  16'h00C3);
        add_row(1'b1, OP_LDI,  4'd11, 4'h0,  4'hF,  16'h000F);
        add_row(1'b1, OP_SHL,  4'd12, 4'd2,  4'd11, 16'h8000);
        add_row(1'b1, OP_SHR,  4'd13, 4'd12, 4'd11, 16'h0001);
        add_row(1'b1, OP_SHR,  4'd14, 4'd5,  4'd6,  16'h1FF2);
        // Negative immediates and back-to-back dependencies.
        add_row(1'b1, OP_ADDI, 4'd1,  4'd1,  4'hF,  16'h0059);
        add_row(1'b1, OP_ADDI, 4'd1,  4'd1,  4'h8,  16'h0051);
        add_row(1'b1, OP_ADD,  4'd2,  4'd1,  4'd1,  16'h00A2);
        add_row(1'b1, OP_SUB,  4'd2,  4'd2,  4'd1,  16'h0051);
        add_row(1'b1, OP_ADDI, 4'd0,  4'd0,  4'h7,  16'h0007);
        add_row(1'b1, OP_ADDI, 4'd15, 4'd0,  4'h8,  16'hFFFF);
        // Address path.
        add_row(1'b1, OP_LEA,  4'd9,  4'd1,  4'd7,  16'h010F);
        add_row(1'b1, OP_LEA,  4'd10, 4'd15, 4'd15, 16'hFFFD);
        add_row(1'b1, OP_ST,   4'd8,  4'd9,  4'h4,  16'h0113);
        add_row(1'b1, OP_ST,   4'd4,  4'd1,  4'hC,  16'h004D);
        // Bubble and no-op codes must leave the registers alone.
        add_row(1'b0, OP_ADD,  4'd1,  4'd2,  4'd3,  16'h0000);
        add_row(1'b1, OP_NOP,  4'd1,  4'd2,  4'd3,  16'h0000);
        add_row(1'b1, 4'd12,   4'd2,  4'd1,  4'd1,  16'h0000);
        add_row(1'b1, 4'd13,   4'd3,  4'd1,  4'd1,  16'h0000);
        add_row(1'b1, 4'd14,   4'd4,  4'd1,  4'd1,  16'h0000);
        add_row(1'b1, 4'd15,   4'd5,  4'd1,  4'd1,  16'h0000);
        add_row(1'b1, OP_OR,   4'd6,  4'd1,  4'd2,  16'h0051);
        add_row(1'b1, OP_XOR,  4'd7,  4'd3,  4'd4,  16'h0112);
        add_row(1'b1, OP_ADD,  4'd8,  4'd5,  4'd0,  16'hFF9E);
    endtask

    initial
    begin
        int          wait_count;
        logic [31:0] bits;
        reset       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        for (int i = 0; i < 16; i++)
        begin
            model_regs[i] = '0;
        end
        build_table();

        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b1;

        foreach (stim_table[i])
        begin
            issue_cycle(stim_table[i].valid, stim_table[i].instr, 1'b1, stim_table[i].value);
        end

        // Random mix with about one bubble in four.
        for (int n = 0; n < RANDOM_COUNT; n++)
        begin
            lfsr_take(2, bits);
            if (bits[1:0] == 2'b00)
            begin
                issue_cycle(1'b0, '0, 1'b0, '0);
            end
            lfsr_take(16, bits);
            issue_cycle(1'b1, instr_t'(bits[15:0]), 1'b0, '0);
        end

        wait_count = 0;
        while (exp_q.size() != 0 && wait_count < DRAIN_LIMIT)
        begin
            issue_cycle(1'b0, '0, 1'b0, '0);
            wait_count++;
        end

        if (exp_q.size() != 0)
        begin
            $display("Timed out with %0d results missing", exp_q.size());
            $display("test failed");
            $fatal(1, "drain timeout");
        end
        else
        begin
            // A few idle cycles catch any stray result.
            repeat (3) issue_cycle(1'b0, '0, 1'b0, '0);
            $display("test passed");
            $finish;
        end
    end

endmodule

`default_nettype wire
